// File: hdl/lsu_macros.svh
// LSU memory map, trigger count and datapath widths
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Datapath
`define LSU_XLEN      32             // Register and address width
`define LSU_OFF_W     12             // Immediate offset width

// DCCM window
`define LSU_DCCM_BASE 32'hF004_0000  // DCCM start address
`define LSU_DCCM_AW   12             // Word address bits, 4096 words
`define LSU_DCCM_HI   (`LSU_DCCM_AW + 2) // Lowest address bit above the DCCM window

// PIC register window
`define LSU_PIC_BASE  32'hF00C_0000  // PIC start address
`define LSU_PIC_AW    10             // Word address bits, 4 KiB window
`define LSU_PIC_HI    (`LSU_PIC_AW + 2)  // Lowest address bit above the PIC window

// Debug triggers
`define LSU_NUM_TRIG  4              // Number of data triggers

`endif

// File: hdl/lsu_pkg.sv
// LSU shared types: operation, region and exception encodings
package lsu_pkg;

    typedef enum logic [2:0] {
        LB  = 3'd0,  // Load byte, signed
        LH  = 3'd1,  // Load half, signed
        LW  = 3'd2,  // Load word
        LBU = 3'd3,  // Load byte, unsigned
        LHU = 3'd4,  // Load half, unsigned
        SB  = 3'd5,  // Store byte
        SH  = 3'd6,  // Store half
        SW  = 3'd7   // Store word
    } lsu_op_e;

    typedef enum logic [1:0] {
        REG_DCCM = 2'd0,  // Data closely coupled memory
        REG_PIC  = 2'd1,  // Interrupt controller registers
        REG_NONE = 2'd2   // Unmapped
    } lsu_region_e;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_MISALIGN = 2'd1,  // Not naturally aligned
        EXC_ACCESS   = 2'd2   // Unmapped or bad width for region
    } lsu_exc_e;

    // True for SB, SH and SW
    function automatic logic op_is_store(input lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // Access size as log2 of bytes: 0 byte, 1 half, 2 word
    function automatic logic [1:0] op_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

endpackage

// File: hdl/lsu_addr_stage.sv
// LSU decode stage
// Forms base plus sign-extended offset and registers the request into M
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_addr_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_d,       // Request strobe
    input  lsu_pkg::lsu_op_e         op_d,          // Load/store kind
    input  logic [`LSU_XLEN-1:0]     rs1_d,         // Base register
    input  logic [`LSU_XLEN-1:0]     rs2_d,         // Store data
    input  logic [`LSU_OFF_W-1:0]    offset_d,      // Signed immediate
    output logic                     valid_m,
    output lsu_pkg::lsu_op_e         op_m,
    output logic [`LSU_XLEN-1:0]     addr_m,        // Effective address
    output logic [`LSU_XLEN-1:0]     store_data_m
);

    logic [`LSU_XLEN-1:0] offset_ext;  // Offset widened to XLEN
    logic [`LSU_XLEN-1:0] addr_d;      // Effective address in D

    // Sign extend 12-bit immediate
    assign offset_ext = {{(`LSU_XLEN - `LSU_OFF_W){offset_d[`LSU_OFF_W-1]}}, offset_d};
    assign addr_d     = rs1_d + offset_ext;  // Wraps modulo 2^32

    // Control flops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_m <= 1'b0;
            op_m    <= lsu_pkg::LB;
        end else begin
            valid_m <= valid_d;
            if (valid_d) begin
                op_m <= op_d;                // Hold op when idle
            end
        end
    end

    // Payload flops, loaded only on a request
    always_ff @(posedge clk) begin
        if (valid_d) begin
            addr_m       <= addr_d;
            store_data_m <= rs2_d;
        end
    end

endmodule

// File: hdl/lsu_access_stage.sv
// LSU M stage: region decode, alignment and access checks, trigger match,
// DCCM/PIC port drive and the M to R pipeline registers
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_access_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_m,                     // Kill instruction in M
    input  logic                        valid_m,
    input  lsu_pkg::lsu_op_e            op_m,
    input  logic [`LSU_XLEN-1:0]        addr_m,
    input  logic [`LSU_XLEN-1:0]        store_data_m,
    input  logic [`LSU_NUM_TRIG-1:0]    trig_select,                 // 0 address, 1 store data
    input  logic [`LSU_NUM_TRIG-1:0]    trig_match,                  // 0 equal, 1 greater-or-equal
    input  logic [`LSU_NUM_TRIG-1:0]    trig_store,
    input  logic [`LSU_NUM_TRIG-1:0]    trig_load,
    input  logic [`LSU_XLEN-1:0]        trig_tdata [`LSU_NUM_TRIG],  // Compare values
    output logic [`LSU_NUM_TRIG-1:0]    lsu_trigger_match_m,
    output logic                        dccm_rden,
    output logic                        dccm_wren,
    output logic [`LSU_DCCM_AW-1:0]     dccm_addr,                   // Word address
    output logic [`LSU_XLEN-1:0]        dccm_wr_data,                // Lane aligned
    output logic [3:0]                  dccm_byte_en,
    output logic                        picm_rden,
    output logic                        picm_wren,
    output logic [`LSU_PIC_AW-1:0]      picm_addr,                   // Word address
    output logic [`LSU_XLEN-1:0]        picm_wr_data,
    output logic                        valid_r,
    output lsu_pkg::lsu_op_e            op_r,
    output lsu_pkg::lsu_region_e        region_r,
    output logic [1:0]                  byte_offset_r,
    output lsu_pkg::lsu_exc_e           exc_r,
    output logic [`LSU_XLEN-1:0]        addr_r
);

    localparam logic [`LSU_XLEN-1:0] DCCM_BASE = `LSU_DCCM_BASE;
    localparam logic [`LSU_XLEN-1:0] PIC_BASE  = `LSU_PIC_BASE;

    logic                   live_m;     // Valid and not flushed
    logic                   is_store_m;
    logic [1:0]             size_m;     // log2 bytes
    logic                   misalign_m;
    logic                   in_dccm_m;
    logic                   in_pic_m;
    lsu_pkg::lsu_region_e   region_m;
    lsu_pkg::lsu_exc_e      exc_m;
    logic                   go_m;       // Clean access, may touch memory

    assign live_m     = valid_m & ~flush_m;
    assign is_store_m = lsu_pkg::op_is_store(op_m);
    assign size_m     = lsu_pkg::op_size(op_m);

    // Natural alignment
    assign misalign_m = ((size_m == 2'd1) & addr_m[0]) |
                        ((size_m == 2'd2) & (|addr_m[1:0]));

    // Region match on the bits above each window
    assign in_dccm_m = (addr_m[`LSU_XLEN-1:`LSU_DCCM_HI] == DCCM_BASE[`LSU_XLEN-1:`LSU_DCCM_HI]);
    assign in_pic_m  = (addr_m[`LSU_XLEN-1:`LSU_PIC_HI] == PIC_BASE[`LSU_XLEN-1:`LSU_PIC_HI]);

    always_comb begin
        if (in_dccm_m) begin
            region_m = lsu_pkg::REG_DCCM;
        end else if (in_pic_m) begin
            region_m = lsu_pkg::REG_PIC;
        end else begin
            region_m = lsu_pkg::REG_NONE;
        end
    end

    // Misalignment wins over access fault
    always_comb begin
        if (misalign_m) begin
            exc_m = lsu_pkg::EXC_MISALIGN;
        end else if ((region_m == lsu_pkg::REG_NONE) ||
                     ((region_m == lsu_pkg::REG_PIC) && (size_m != 2'd2))) begin
            exc_m = lsu_pkg::EXC_ACCESS;  // PIC is word only
        end else begin
            exc_m = lsu_pkg::EXC_NONE;
        end
    end

    assign go_m = live_m & (exc_m == lsu_pkg::EXC_NONE);

    // DCCM port
    assign dccm_rden    = go_m & (region_m == lsu_pkg::REG_DCCM) & ~is_store_m;
    assign dccm_wren    = go_m & (region_m == lsu_pkg::REG_DCCM) & is_store_m;
    assign dccm_addr    = addr_m[`LSU_DCCM_AW+1:2];
    assign dccm_wr_data = store_data_m << {addr_m[1:0], 3'b000};  // Move to byte lane

    always_comb begin
        case (size_m)
            2'd0:    dccm_byte_en = 4'b0001 << addr_m[1:0];
            2'd1:    dccm_byte_en = 4'b0011 << addr_m[1:0];
            default: dccm_byte_en = 4'b1111;
        endcase
    end

    // PIC port, whole words only
    assign picm_rden    = go_m & (region_m == lsu_pkg::REG_PIC) & ~is_store_m;
    assign picm_wren    = go_m & (region_m == lsu_pkg::REG_PIC) & is_store_m;
    assign picm_addr    = addr_m[`LSU_PIC_AW+1:2];
    assign picm_wr_data = store_data_m;

    // Data triggers, reported only and never block the access
    for (genvar i = 0; i < `LSU_NUM_TRIG; i++) begin : g_trig
        logic [`LSU_XLEN-1:0] cmp_val;
        logic                 val_hit;
        logic                 kind_hit;

        assign cmp_val  = trig_select[i] ? store_data_m : addr_m;
        assign val_hit  = trig_match[i] ? (cmp_val >= trig_tdata[i])   // Unsigned
                                        : (cmp_val == trig_tdata[i]);
        assign kind_hit = (trig_load[i] & ~is_store_m) | (trig_store[i] & is_store_m);
        assign lsu_trigger_match_m[i] = live_m & kind_hit & val_hit;
    end

    // M to R control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r  <= 1'b0;
            op_r     <= lsu_pkg::LB;
            region_r <= lsu_pkg::REG_NONE;
            exc_r    <= lsu_pkg::EXC_NONE;
        end else begin
            valid_r <= live_m;            // Flushed op dies here
            if (live_m) begin
                op_r     <= op_m;
                region_r <= region_m;
                exc_r    <= exc_m;
            end
        end
    end

    // M to R payload
    always_ff @(posedge clk) begin
        if (live_m) begin
            byte_offset_r <= addr_m[1:0];
            addr_r        <= addr_m;      // Kept for fault reporting
        end
    end

endmodule

// File: hdl/lsu_result_stage.sv
// LSU R stage: picks and aligns the returned read data, extends it per op
// and splits the instruction into a result or an exception
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_result_stage (
    input  logic                     valid_r,
    input  lsu_pkg::lsu_op_e         op_r,
    input  lsu_pkg::lsu_region_e     region_r,
    input  logic [1:0]               byte_offset_r,
    input  lsu_pkg::lsu_exc_e        exc_r,
    input  logic [`LSU_XLEN-1:0]     addr_r,
    input  logic [`LSU_XLEN-1:0]     dccm_rd_data,       // One cycle after rden
    input  logic [`LSU_XLEN-1:0]     picm_rd_data,
    output logic                     result_valid_r,
    output logic [`LSU_XLEN-1:0]     lsu_result_r,       // Zero for stores
    output logic                     lsu_error_valid_r,
    output lsu_pkg::lsu_exc_e        lsu_error_exc_r,
    output logic                     lsu_error_store_r,  // Fault was on a store
    output logic [`LSU_XLEN-1:0]     lsu_error_addr_r
);

    logic [`LSU_XLEN-1:0] rd_word;     // Raw word from the selected memory
    logic [`LSU_XLEN-1:0] rd_shift;    // Addressed byte moved to bit 0
    logic [`LSU_XLEN-1:0] load_data;   // Extended per op
    logic                 is_store_r;
    logic                 fault_r;

    assign is_store_r = lsu_pkg::op_is_store(op_r);
    assign fault_r    = (exc_r != lsu_pkg::EXC_NONE);

    // Region select then lane shift
    assign rd_word  = (region_r == lsu_pkg::REG_PIC) ? picm_rd_data : dccm_rd_data;
    assign rd_shift = rd_word >> {byte_offset_r, 3'b000};

    always_comb begin
        case (op_r)
            lsu_pkg::LB:  load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::LBU: load_data = {24'd0, rd_shift[7:0]};
            lsu_pkg::LH:  load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            lsu_pkg::LHU: load_data = {16'd0, rd_shift[15:0]};
            lsu_pkg::LW:  load_data = rd_shift;
            default:      load_data = '0;  // Stores return nothing
        endcase
    end

    // Good completion
    assign result_valid_r = valid_r & ~fault_r;
    assign lsu_result_r   = result_valid_r ? load_data : '0;

    // Exception report, quiet when nothing faulted
    assign lsu_error_valid_r = valid_r & fault_r;
    assign lsu_error_exc_r   = lsu_error_valid_r ? exc_r : lsu_pkg::EXC_NONE;
    assign lsu_error_store_r = lsu_error_valid_r & is_store_r;
    assign lsu_error_addr_r  = lsu_error_valid_r ? addr_r : '0;

endmodule

// File: hdl/lsu_top.sv
// LSU top level: chains address, access and result stages and routes
// the per-field trigger vectors into the access stage
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_m,
    input  logic                        valid_d,
    input  lsu_pkg::lsu_op_e            op_d,
    input  logic [`LSU_XLEN-1:0]        rs1_d,
    input  logic [`LSU_XLEN-1:0]        rs2_d,
    input  logic [`LSU_OFF_W-1:0]       offset_d,
    // Unpacked trigger descriptors
    input  logic [`LSU_NUM_TRIG-1:0]    select,
    input  logic [`LSU_NUM_TRIG-1:0]    match,
    input  logic [`LSU_NUM_TRIG-1:0]    store,
    input  logic [`LSU_NUM_TRIG-1:0]    load,
    input  logic [`LSU_XLEN-1:0]        tdata [`LSU_NUM_TRIG],
    output logic [`LSU_NUM_TRIG-1:0]    lsu_trigger_match_m,
    // DCCM
    output logic                        dccm_rden,
    output logic                        dccm_wren,
    output logic [`LSU_DCCM_AW-1:0]     dccm_addr,
    output logic [`LSU_XLEN-1:0]        dccm_wr_data,
    output logic [3:0]                  dccm_byte_en,
    input  logic [`LSU_XLEN-1:0]        dccm_rd_data,
    // PIC
    output logic                        picm_rden,
    output logic                        picm_wren,
    output logic [`LSU_PIC_AW-1:0]      picm_addr,
    output logic [`LSU_XLEN-1:0]        picm_wr_data,
    input  logic [`LSU_XLEN-1:0]        picm_rd_data,
    // Result and exception
    output logic                        result_valid_r,
    output logic [`LSU_XLEN-1:0]        lsu_result_r,
    output logic                        lsu_error_valid_r,
    output lsu_pkg::lsu_exc_e           lsu_error_exc_r,
    output logic                        lsu_error_store_r,
    output logic [`LSU_XLEN-1:0]        lsu_error_addr_r
);

    // D to M
    logic                   valid_m;
    lsu_pkg::lsu_op_e       op_m;
    logic [`LSU_XLEN-1:0]   addr_m;
    logic [`LSU_XLEN-1:0]   store_data_m;

    // M to R
    logic                   valid_r;
    lsu_pkg::lsu_op_e       op_r;
    lsu_pkg::lsu_region_e   region_r;
    logic [1:0]             byte_offset_r;
    lsu_pkg::lsu_exc_e      exc_r;
    logic [`LSU_XLEN-1:0]   addr_r;

    lsu_addr_stage u_addr (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_d      (valid_d),
        .op_d         (op_d),
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .offset_d     (offset_d),
        .valid_m      (valid_m),
        .op_m         (op_m),
        .addr_m       (addr_m),
        .store_data_m (store_data_m)
    );

    lsu_access_stage u_access (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush_m             (flush_m),
        .valid_m             (valid_m),
        .op_m                (op_m),
        .addr_m              (addr_m),
        .store_data_m        (store_data_m),
        .trig_select         (select),   // Trigger fields pass straight through
        .trig_match          (match),
        .trig_store          (store),
        .trig_load           (load),
        .trig_tdata          (tdata),
        .lsu_trigger_match_m (lsu_trigger_match_m),
        .dccm_rden           (dccm_rden),
        .dccm_wren           (dccm_wren),
        .dccm_addr           (dccm_addr),
        .dccm_wr_data        (dccm_wr_data),
        .dccm_byte_en        (dccm_byte_en),
        .picm_rden           (picm_rden),
        .picm_wren           (picm_wren),
        .picm_addr           (picm_addr),
        .picm_wr_data        (picm_wr_data),
        .valid_r             (valid_r),
        .op_r                (op_r),
        .region_r            (region_r),
        .byte_offset_r       (byte_offset_r),
        .exc_r               (exc_r),
        .addr_r              (addr_r)
    );

    lsu_result_stage u_result (
        .valid_r           (valid_r),
        .op_r              (op_r),
        .region_r          (region_r),
        .byte_offset_r     (byte_offset_r),
        .exc_r             (exc_r),
        .addr_r            (addr_r),
        .dccm_rd_data      (dccm_rd_data),
        .picm_rd_data      (picm_rd_data),
        .result_valid_r    (result_valid_r),
        .lsu_result_r      (lsu_result_r),
        .lsu_error_valid_r (lsu_error_valid_r),
        .lsu_error_exc_r   (lsu_error_exc_r),
        .lsu_error_store_r (lsu_error_store_r),
        .lsu_error_addr_r  (lsu_error_addr_r)
    );

endmodule

// File: testbench/lsu_props.sv
// LSU access stage checks: memory port exclusivity and quiet enables
`timescale 1ns/1ps

module lsu_props (
    input logic              clk,
    input logic              rst_n,
    input logic              flush_m,
    input lsu_pkg::lsu_exc_e exc_m,
    input logic              dccm_rden,
    input logic              dccm_wren,
    input logic              picm_rden,
    input logic              picm_wren
);

    logic any_en;  // Some memory enable is up

    assign any_en = dccm_rden | dccm_wren | picm_rden | picm_wren;

    // DCCM reads and writes are exclusive
    a_dccm_rw: assert property (@(posedge clk) disable iff (!rst_n)
        !(dccm_rden && dccm_wren))
        else $error("dccm_rden and dccm_wren high together");

    // Faulting or flushed op leaves memory alone
    a_quiet_fault: assert property (@(posedge clk) disable iff (!rst_n)
        ((exc_m != lsu_pkg::EXC_NONE) || flush_m) |-> !any_en)
        else $error("memory enable high on faulting or flushed op");

    // Enables stay low in reset
    a_quiet_reset: assert property (@(posedge clk) !rst_n |-> !any_en)
        else $error("memory enable high during reset");

endmodule

bind lsu_access_stage lsu_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush_m   (flush_m),
    .exc_m     (exc_m),
    .dccm_rden (dccm_rden),
    .dccm_wren (dccm_wren),
    .picm_rden (picm_rden),
    .picm_wren (picm_wren)
);

// File: testbench/lsu_tb.sv
// LSU testbench running a table of loads and stores back to back
// against DCCM and PIC models with a byte-level reference copy of memory
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;

    localparam logic [31:0] D = `LSU_DCCM_BASE;
    localparam logic [31:0] P = `LSU_PIC_BASE;

    logic clk, rst_n, flush_m, valid_d;
    lsu_pkg::lsu_op_e op_d;
    logic [31:0] rs1_d, rs2_d;
    logic [11:0] offset_d;
    logic [3:0] select, match, store, load, lsu_trigger_match_m;
    logic [31:0] tdata [4];
    logic dccm_rden, dccm_wren, picm_rden, picm_wren;
    logic [11:0] dccm_addr;
    logic [9:0] picm_addr;
    logic [31:0] dccm_wr_data, picm_wr_data, dccm_rd_data, picm_rd_data;
    logic [3:0] dccm_byte_en;
    logic result_valid_r, lsu_error_valid_r, lsu_error_store_r;
    logic [31:0] lsu_result_r, lsu_error_addr_r;
    lsu_pkg::lsu_exc_e lsu_error_exc_r;

    logic [31:0] dccm_mem [4096];       // DCCM model
    logic [31:0] pic_mem [1024];        // Word-only PIC model
    logic [7:0] ref_bytes [16384];      // Byte-wide reference DCCM
    logic [31:0] ref_pic [1024];
    logic [15:0] lfsr = 16'd52475;

    // Stimulus table
    lsu_pkg::lsu_op_e t_op [64];
    logic [31:0] t_rs1 [64], t_rs2 [64];
    logic [11:0] t_off [64];
    logic t_flush [64], t_rnd [64], t_trig [64];
    lsu_pkg::lsu_exc_e t_exc [64];
    logic [3:0] t_mask [64];
    int n_rows = 0;

    // Expected R-stage outputs per cycle slot
    logic [31:0] q_rv [$], q_res [$], q_ev [$], q_exc [$], q_st [$], q_addr [$];
    logic [3:0] exp_trig;               // Mask for the op now in M
    int cycles = 0;
    int max_cycles = 1000;

    lsu_top uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run still busy after %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Synchronous memories
    always @(posedge clk) begin
        if (dccm_wren) begin
            for (int b = 0; b < 4; b++)
                if (dccm_byte_en[b]) dccm_mem[dccm_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];
        end
        if (dccm_rden) dccm_rd_data <= dccm_mem[dccm_addr];
        if (picm_wren) pic_mem[picm_addr] <= picm_wr_data;
        if (picm_rden) picm_rd_data <= pic_mem[picm_addr];
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B9) ^ {a[15:0], ~a[15:0]};  // Every address bit counts
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand32(output logic [31:0] r);
        for (int k = 0; k < 32; k++) begin
            r[k] = lfsr[0];             // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input lsu_pkg::lsu_op_e op, input logic [31:0] rs1, rs2,
                           input logic [11:0] off, input logic fl, rnd, trig,
                           input lsu_pkg::lsu_exc_e exc, input logic [3:0] mask);
        t_op[n_rows] = op;
        t_rs1[n_rows] = rs1;
        t_rs2[n_rows] = rs2;
        t_off[n_rows] = off;
        t_flush[n_rows] = fl;
        t_rnd[n_rows] = rnd;
        t_trig[n_rows] = trig;
        t_exc[n_rows] = exc;
        t_mask[n_rows] = mask;
        n_rows++;
    endtask

    // Triggers 0 load addr eq, 1 store addr ge, 2 store data eq, 3 any addr ge
    task automatic set_trig(input logic on);
        select = on ? 4'b0100 : 4'b0000;
        match  = on ? 4'b1010 : 4'b0000;
        store  = on ? 4'b1110 : 4'b0000;
        load   = on ? 4'b1001 : 4'b0000;
    endtask

    task automatic push_exp(input logic rv, input logic [31:0] res, input logic ev,
                            input lsu_pkg::lsu_exc_e exc, input logic st,
                            input logic [31:0] addr);
        q_rv.push_back(rv);
        q_res.push_back(res);
        q_ev.push_back(ev);
        q_exc.push_back(exc);
        q_st.push_back(st);
        q_addr.push_back(addr);
    endtask

    // Drive one row and model its effect in request order
    task automatic issue(input int i);
        logic [31:0] a, data, w;
        int nb, base;
        logic is_st;
        a = t_rs1[i] + {{20{t_off[i][11]}}, t_off[i]};
        data = t_rs2[i];
        if (t_rnd[i]) rand32(data);
        valid_d = 1'b1;
        op_d = t_op[i];
        rs1_d = t_rs1[i];
        rs2_d = data;
        offset_d = t_off[i];
        is_st = t_op[i] inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
        nb = (t_op[i] inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB}) ? 1 :
             (t_op[i] inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) ? 2 : 4;
        if (t_flush[i]) begin
            push_exp(0, 0, 0, lsu_pkg::EXC_NONE, 0, 0);   // Vanishes entirely
        end else if (t_exc[i] != lsu_pkg::EXC_NONE) begin
            push_exp(0, 0, 1, t_exc[i], is_st, a);
        end else if (a[31:14] == D[31:14]) begin
            base = int'(a[13:2]) * 4;
            if (is_st) begin
                for (int b = 0; b < nb; b++) ref_bytes[a[13:0] + b] = data[8*b +: 8];
                push_exp(1, 0, 0, lsu_pkg::EXC_NONE, 0, 0);
            end else begin
                for (int b = 0; b < 4; b++) w[8*b +: 8] = ref_bytes[base + b];
                w = w >> (8 * a[1:0]);
                case (t_op[i])
                    lsu_pkg::LB:  w = {{24{w[7]}}, w[7:0]};
                    lsu_pkg::LBU: w = {24'd0, w[7:0]};
                    lsu_pkg::LH:  w = {{16{w[15]}}, w[15:0]};
                    lsu_pkg::LHU: w = {16'd0, w[15:0]};
                    default:      w = w;
                endcase
                push_exp(1, w, 0, lsu_pkg::EXC_NONE, 0, 0);
            end
        end else begin                                  // PIC is word only
            if (is_st) ref_pic[a[11:2]] = data;
            push_exp(1, is_st ? 32'd0 : ref_pic[a[11:2]], 0, lsu_pkg::EXC_NONE, 0, 0);
        end
    endtask

    initial begin
        logic [31:0] w;
        rst_n = 1'b0;
        flush_m = 1'b0;
        valid_d = 1'b0;
        op_d = lsu_pkg::LB;
        rs1_d = '0;
        rs2_d = '0;
        offset_d = '0;
        tdata = '{D + 32'h100, D + 32'h200, 32'hCAFE_F00D, D};
        set_trig(1'b0);
        dccm_rd_data = '0;
        picm_rd_data = '0;
        for (int k = 0; k < 4096; k++) begin
            dccm_mem[k] = fill_word(D + 4 * k);
            for (int b = 0; b < 4; b++) ref_bytes[4*k + b] = dccm_mem[k][8*b +: 8];
        end
        for (int k = 0; k < 1024; k++) begin
            pic_mem[k] = fill_word(P + 4 * k);
            ref_pic[k] = pic_mem[k];
        end
        // Stores then loads of every width back to back
        add_row(lsu_pkg::SW, D, 32'h1122_3344, 12'h100, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::SH, D, 32'hAAAA_BEEF, 12'h104, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::SB, D, 32'h0000_005A, 12'h107, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LW, D, 0, 12'h100, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h9);
        add_row(lsu_pkg::LB, D, 0, 12'h103, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LBU, D, 0, 12'h107, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LH, D, 0, 12'h104, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LHU, D, 0, 12'h106, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::SW, D, 32'hCAFE_F00D, 12'h200, 0, 0, 1, lsu_pkg::EXC_NONE, 4'hE);
        add_row(lsu_pkg::LH, D, 0, 12'h202, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LBU, D, 0, 12'h201, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        // PIC round trip and bad width
        add_row(lsu_pkg::SW, P, 32'h8765_4321, 12'h010, 0, 0, 1, lsu_pkg::EXC_NONE, 4'hA);
        add_row(lsu_pkg::LW, P, 0, 12'h010, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::SH, P, 32'h0000_1234, 12'h020, 0, 0, 1, lsu_pkg::EXC_ACCESS, 4'hA);
        // Misaligned and unmapped
        add_row(lsu_pkg::LH, D, 0, 12'h101, 0, 0, 1, lsu_pkg::EXC_MISALIGN, 4'h8);
        add_row(lsu_pkg::SW, D, 32'h0BAD_0BAD, 12'h102, 0, 0, 1, lsu_pkg::EXC_MISALIGN, 4'h8);
        add_row(lsu_pkg::LW, 32'h1000_0000, 0, 12'h000, 0, 0, 1, lsu_pkg::EXC_ACCESS, 4'h0);
        // Flushed store between live neighbours
        add_row(lsu_pkg::SW, D, 32'hDEAD_DEAD, 12'h300, 1, 0, 1, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LW, D, 0, 12'h300, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        add_row(lsu_pkg::LW, D, 0, 12'h100, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h9);
        add_row(lsu_pkg::LW, D + 32'h400, 0, 12'hF00, 0, 0, 1, lsu_pkg::EXC_NONE, 4'h8);
        // Random store data with triggers off
        add_row(lsu_pkg::SW, D, 0, 12'h500, 0, 1, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LW, D, 0, 12'h500, 0, 0, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::SH, D, 0, 12'h508, 0, 1, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LH, D, 0, 12'h508, 0, 0, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::SB, D, 0, 12'h50B, 0, 1, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LB, D, 0, 12'h50B, 0, 0, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LHU, D, 0, 12'h508, 0, 0, 0, lsu_pkg::EXC_NONE, 4'h0);
        add_row(lsu_pkg::LBU, D, 0, 12'h501, 0, 0, 0, lsu_pkg::EXC_NONE, 4'h0);
        max_cycles = n_rows + 4 + 3 + 10;   // Rows, drain, reset, margin

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        exp_trig = 4'h0;
        for (int i = 0; i < n_rows + 4; i++) begin
            @(negedge clk);
            if (i >= 2) begin                   // R outputs of row i-2
                check("result_valid_r", result_valid_r, q_rv.pop_front());
                check("lsu_result_r", lsu_result_r, q_res.pop_front());
                check("lsu_error_valid_r", lsu_error_valid_r, q_ev.pop_front());
                check("lsu_error_exc_r", lsu_error_exc_r, q_exc.pop_front());
                check("lsu_error_store_r", lsu_error_store_r, q_st.pop_front());
                check("lsu_error_addr_r", lsu_error_addr_r, q_addr.pop_front());
            end
            // Row i-1 now sits in M
            flush_m = (i >= 1 && i <= n_rows) ? t_flush[i-1] : 1'b0;
            set_trig((i >= 1 && i <= n_rows) ? t_trig[i-1] : 1'b0);
            exp_trig = (i >= 1 && i <= n_rows) ? t_mask[i-1] : 4'h0;
            if (i < n_rows) begin
                issue(i);
            end else begin
                valid_d = 1'b0;
                if (i < n_rows + 2) begin
                    push_exp(0, 0, 0, lsu_pkg::EXC_NONE, 0, 0);  // Idle slot stays quiet
                end
            end
            #1;
            check("lsu_trigger_match_m", lsu_trigger_match_m, exp_trig);
        end
        @(negedge clk);
        // Memories must match the reference copy word for word
        for (int k = 0; k < 4096; k++) begin
            for (int b = 0; b < 4; b++) w[8*b +: 8] = ref_bytes[4*k + b];
            check("dccm_mem", dccm_mem[k], w);
        end
        for (int k = 0; k < 1024; k++) check("pic_mem", pic_mem[k], ref_pic[k]);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_addr_stage.sv
hdl/lsu_access_stage.sv
hdl/lsu_result_stage.sv
hdl/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_tb.sv
